// File: all.f
+incdir+bench
source/rt_scene_pkg.sv
source/rt_types_pkg.sv
source/ray_gen.sv
source/stream_fifo.sv
source/scene_int.sv
source/pixel_arbiter.sv
source/frame_buffer_writer.sv
source/raytrace_demo.sv
bench/raytrace_demo_tb.sv

// File: bench/raytrace_demo_tb_ref.svh
// Reference colors and image checks
`ifndef RAYTRACE_DEMO_TB_REF_SVH
`define RAYTRACE_DEMO_TB_REF_SVH

// Compare two values and count a mismatch
task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	if (expected !== actual) begin
		$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
		errors++;
	end
endtask

// White inside the box, bounds included, blue everywhere else
function automatic color_t expected_color(input int col, input int row,
		input coord_t cx, input coord_t cy, input coord_t xmin,
		input coord_t xmax, input coord_t ymin, input coord_t ymax);
	int ox;
	int oy;
	ox = col + cx;
	oy = row + cy;
	if (ox >= xmin && ox <= xmax && oy >= ymin && oy <= ymax)
		return COLOR_HIT;
	return COLOR_MISS;
endfunction

// Every address holds its reference color and was written once
task automatic check_image(input coord_t cx, input coord_t cy, input coord_t xmin,
		input coord_t xmax, input coord_t ymin, input coord_t ymax);
	int a;
	int col;
	int row;
	for (a = 0; a < NUM_PIXELS; a++) begin
		col = a % SCREEN_W;
		row = a / SCREEN_W;
		check($sformatf("%s color at %0d", current_test, a),
			expected_color(col, row, cx, cy, xmin, xmax, ymin, ymax), mem_color[a]);
		check($sformatf("%s writes to %0d", current_test, a), 1, write_count[a]);
	end
endtask

`endif

// File: bench/raytrace_demo_tb.sv
// Ray-casting demo testbench
`timescale 1ns/1ps

module raytrace_demo_tb
	import rt_scene_pkg::*, rt_types_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 6 * NUM_PIXELS * 8;
	// Quiet period after frame_done to catch late writes
	localparam int SETTLE_CYCLES = 32;

	logic clk;
	logic arst_n;
	logic start;
	coord_t cam_x;
	coord_t cam_y;
	coord_t box_xmin;
	coord_t box_xmax;
	coord_t box_ymin;
	coord_t box_ymax;
	logic fb_stall;
	logic fb_we;
	pixel_id_t fb_addr;
	color_t fb_color;
	logic frame_done;
	logic busy;

	// Memory model and frame bookkeeping
	color_t mem_color [NUM_PIXELS];
	int write_count [NUM_PIXELS];
	int total_writes;
	int writes_at_done;
	int done_count;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycle_cnt = 0;
	integer seed = 32'h8566_9ba0;
	logic stall_random = 1'b0;
	logic prev_stall = 1'b0;
	string current_test = "reset";

	`include "raytrace_demo_tb_ref.svh"

	raytrace_demo raytrace_demo_i (.clk, .arst_n, .start, .cam_x, .cam_y,
		.box_xmin, .box_xmax, .box_ymin, .box_ymax,
		.fb_stall, .fb_we, .fb_addr, .fb_color, .frame_done, .busy);

	always #4 clk = ~clk;

	// Random memory back-pressure about half the time when enabled
	always @(posedge clk)
		fb_stall <= stall_random && ($random(seed) & 1);

	// Memory write port model
	always @(negedge clk) begin
		if (frame_done) begin
			if (done_count == 0)
				writes_at_done = total_writes;
			done_count++;
		end
		if (fb_we) begin
			check({current_test, " fb_we after stall"}, 0, prev_stall);
			check({current_test, " address range"}, 1, fb_addr < NUM_PIXELS);
			mem_color[fb_addr] = fb_color;
			write_count[fb_addr]++;
			total_writes++;
		end
		prev_stall = fb_stall;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: test %s hung without finishing its frame", current_test);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// One frame with the given camera and box, then its checks
	task automatic run_frame(input string name, input coord_t cx, input coord_t cy,
			input coord_t xmin, input coord_t xmax, input coord_t ymin,
			input coord_t ymax, input bit random_stall, input bit restart);
		bit restarted;
		int a;
		restarted = 1'b0;
		current_test = name;
		total_writes = 0;
		writes_at_done = 0;
		done_count = 0;
		// Address-dependent fill that matches neither pixel color
		for (a = 0; a < NUM_PIXELS; a++) begin
			mem_color[a] = color_t'(24'hBA_D0_00 + a);
			write_count[a] = 0;
		end
		@(posedge clk);
		cam_x <= cx;
		cam_y <= cy;
		box_xmin <= xmin;
		box_xmax <= xmax;
		box_ymin <= ymin;
		box_ymax <= ymax;
		stall_random <= random_stall;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check({name, " busy after start"}, 1, busy);
		while (!frame_done) begin
			@(negedge clk);
			// Second start in mid-frame must be ignored
			if (restart && !restarted && total_writes >= NUM_PIXELS / 2) begin
				restarted = 1'b1;
				@(posedge clk);
				start <= 1'b1;
				@(posedge clk);
				start <= 1'b0;
			end
		end
		check({name, " busy at frame_done"}, 0, busy);
		@(posedge clk);
		stall_random <= 1'b0;
		repeat (SETTLE_CYCLES) @(posedge clk);
		@(negedge clk);
		check({name, " writes before frame_done"}, NUM_PIXELS, writes_at_done);
		check({name, " total writes"}, NUM_PIXELS, total_writes);
		check({name, " frame_done pulses"}, 1, done_count);
		check({name, " busy after frame"}, 0, busy);
		check_image(cx, cy, xmin, xmax, ymin, ymax);
		if (errors == 0) begin
			$display("Test %s passed", name);
			tests_passed++;
		end else begin
			$display("Test %s failed with %0d errors", name, errors);
			tests_failed++;
		end
		errors = 0;
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		start = 1'b0;
		cam_x = '0;
		cam_y = '0;
		box_xmin = '0;
		box_xmax = '0;
		box_ymin = '0;
		box_ymax = '0;
		fb_stall = 1'b0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check("busy after reset", 0, busy);
		run_frame("centered_box", 0, 0, 4, 11, 3, 8, 1'b0, 1'b0);
		run_frame("camera_offset", 3, -2, 4, 11, 3, 8, 1'b0, 1'b0);
		run_frame("empty_box", 0, 0, 5, 2, 0, 11, 1'b0, 1'b0);
		run_frame("full_box", 0, 0, -100, 100, -100, 100, 1'b0, 1'b0);
		run_frame("random_stall", 1, 1, 4, 11, 3, 8, 1'b1, 1'b0);
		run_frame("restart_ignored", 0, 0, 4, 11, 3, 8, 1'b0, 1'b1);
		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule : raytrace_demo_tb

// File: source/frame_buffer_writer.sv
// Frame buffer write port driver
`timescale 1ns/1ps

module frame_buffer_writer
	import rt_scene_pkg::*, rt_types_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic px_valid,
	output logic px_stall,
	input pixel_entry_t px,
	input logic fb_stall,
	output logic fb_we,
	output pixel_id_t fb_addr,
	output color_t fb_color,
	output logic frame_done
);

	logic pop;
	pixel_id_t wr_cnt;
	logic last_wr;

	// Memory back-pressure holds the queue directly
	assign px_stall = fb_stall;
	assign pop = px_valid && !fb_stall;

	assign last_wr = fb_we && (wr_cnt == NUM_PIXELS - 1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fb_we <= 1'b0;
			frame_done <= 1'b0;
			wr_cnt <= '0;
		end else begin
			fb_we <= pop;
			frame_done <= last_wr;
			// Count wraps at the end of each frame
			if (last_wr)
				wr_cnt <= '0;
			else if (fb_we)
				wr_cnt <= wr_cnt + 1'b1;
		end
	end

	// Address is the pixel number
	always_ff @(posedge clk) begin
		if (pop) begin
			fb_addr <= px.pixel_id;
			fb_color <= px.color;
		end
	end

endmodule : frame_buffer_writer

// File: source/pixel_arbiter.sv
// Two-way round-robin merge
`timescale 1ns/1ps

module pixel_arbiter #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic arst_n,
	input logic a_valid,
	output logic a_stall,
	input payload_t a_data,
	input logic b_valid,
	output logic b_stall,
	input payload_t b_data,
	output logic out_valid,
	input logic out_stall,
	output payload_t out_data
);

	logic prio_b;
	logic ready;
	logic grant_a;
	logic grant_b;

	// Output register can load when empty or draining this cycle
	assign ready = !out_valid || !out_stall;

	// Contention goes to whoever holds priority
	assign grant_a = a_valid && (!b_valid || !prio_b);
	assign grant_b = b_valid && (!a_valid || prio_b);

	assign a_stall = !(ready && grant_a);
	assign b_stall = !(ready && grant_b);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			prio_b <= 1'b0;
		end else if (ready) begin
			out_valid <= grant_a || grant_b;
			// Flip only after a contested grant
			if (a_valid && b_valid)
				prio_b <= !prio_b;
		end
	end

	always_ff @(posedge clk) begin
		if (ready && (grant_a || grant_b))
			out_data <= grant_a ? a_data : b_data;
	end

endmodule : pixel_arbiter

// File: source/ray_gen.sv
// Orthographic ray generator
`timescale 1ns/1ps

module ray_gen
	import rt_scene_pkg::*, rt_types_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic start,
	input coord_t cam_x,
	input coord_t cam_y,
	output logic ray_valid,
	input logic ray_stall,
	output ray_t ray,
	input logic frame_done,
	output logic busy
);

	coord_t col;
	coord_t row;
	logic busy_r;
	logic idle;
	logic last_px;
	logic advance;

	// Frame counts as finished in the cycle the writer reports it
	assign idle = !busy_r || frame_done;
	assign busy = busy_r && !frame_done;

	assign last_px = (col == SCREEN_W - 1) && (row == SCREEN_H - 1);
	assign advance = ray_valid && !ray_stall;

	// Origin is the pixel position shifted by the camera
	assign ray.pixel_id = pixel_id_t'(row * SCREEN_W + col);
	assign ray.origin_x = col + cam_x;
	assign ray.origin_y = row + cam_y;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_r <= 1'b0;
			ray_valid <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (start && idle) begin
			busy_r <= 1'b1;
			ray_valid <= 1'b1;
			col <= '0;
			row <= '0;
		end else begin
			if (frame_done)
				busy_r <= 1'b0;
			if (advance) begin
				// Walk columns first, then rows
				if (last_px) begin
					ray_valid <= 1'b0;
				end else if (col == SCREEN_W - 1) begin
					col <= '0;
					row <= row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

endmodule : ray_gen

// File: source/raytrace_demo.sv
// Ray-casting demo top level
`timescale 1ns/1ps

module raytrace_demo
	import rt_scene_pkg::*, rt_types_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic start,
	input coord_t cam_x,
	input coord_t cam_y,
	input coord_t box_xmin,
	input coord_t box_xmax,
	input coord_t box_ymin,
	input coord_t box_ymax,
	input logic fb_stall,
	output logic fb_we,
	output pixel_id_t fb_addr,
	output color_t fb_color,
	output logic frame_done,
	output logic busy
);

	// Generator to ray queue
	logic gen_valid, gen_stall;
	ray_t gen_ray;

	// Ray queue to intersection
	logic si_valid, si_stall;
	ray_t si_ray;

	// Hit and miss pixel streams
	logic hit_valid, hit_stall, miss_valid, miss_stall;
	pixel_entry_t hit_data, miss_data;

	// Arbiter to pixel queue, pixel queue to writer
	logic arb_valid, arb_stall, px_valid, px_stall;
	pixel_entry_t arb_data, px;

	ray_gen ray_gen_i (.clk, .arst_n, .start, .cam_x, .cam_y,
		.ray_valid(gen_valid), .ray_stall(gen_stall), .ray(gen_ray),
		.frame_done, .busy);

	stream_fifo #(.payload_t(ray_t), .DEPTH(RAY_FIFO_DEPTH)) ray_fifo_i (
		.clk, .arst_n,
		.in_valid(gen_valid), .in_stall(gen_stall), .in_data(gen_ray),
		.out_valid(si_valid), .out_stall(si_stall), .out_data(si_ray));

	scene_int scene_int_i (.clk, .arst_n,
		.ray_valid(si_valid), .ray_stall(si_stall), .ray(si_ray),
		.box_xmin, .box_xmax, .box_ymin, .box_ymax,
		.hit_valid, .hit_stall, .hit_data,
		.miss_valid, .miss_stall, .miss_data);

	pixel_arbiter #(.payload_t(pixel_entry_t)) pixel_arbiter_i (.clk, .arst_n,
		.a_valid(hit_valid), .a_stall(hit_stall), .a_data(hit_data),
		.b_valid(miss_valid), .b_stall(miss_stall), .b_data(miss_data),
		.out_valid(arb_valid), .out_stall(arb_stall), .out_data(arb_data));

	stream_fifo #(.payload_t(pixel_entry_t), .DEPTH(PIXEL_FIFO_DEPTH)) pixel_fifo_i (
		.clk, .arst_n,
		.in_valid(arb_valid), .in_stall(arb_stall), .in_data(arb_data),
		.out_valid(px_valid), .out_stall(px_stall), .out_data(px));

	frame_buffer_writer frame_buffer_writer_i (.clk, .arst_n,
		.px_valid, .px_stall, .px,
		.fb_stall, .fb_we, .fb_addr, .fb_color, .frame_done);

endmodule : raytrace_demo

// File: source/rt_scene_pkg.sv
// Scene geometry and colors
package rt_scene_pkg;

	// Screen size in pixels
	localparam int SCREEN_W = 16;
	localparam int SCREEN_H = 12;
	localparam int NUM_PIXELS = SCREEN_W * SCREEN_H;

	// Field widths
	localparam int PIXEL_ID_W = 8;
	localparam int COORD_W = 10;

	// 24-bit RGB pixel colors
	localparam logic [23:0] COLOR_HIT = 24'hFF_FF_FF;
	localparam logic [23:0] COLOR_MISS = 24'h00_00_FF;

	// Queue depths
	localparam int RAY_FIFO_DEPTH = 4;
	localparam int PIXEL_FIFO_DEPTH = 8;

endpackage : rt_scene_pkg

// File: source/rt_types_pkg.sv
// Stage payload types
package rt_types_pkg;

	import rt_scene_pkg::*;

	// Pixel number, row * SCREEN_W + column
	typedef logic [PIXEL_ID_W-1:0] pixel_id_t;

	// Small signed integer coordinate
	typedef logic signed [COORD_W-1:0] coord_t;

	// RGB, 8 bits per channel
	typedef logic [23:0] color_t;

	// Ray from the generator to the intersection stage
	typedef struct packed {
		pixel_id_t pixel_id;
		coord_t origin_x;
		coord_t origin_y;
	} ray_t;

	// Colored pixel on its way to the frame buffer
	typedef struct packed {
		pixel_id_t pixel_id;
		color_t color;
	} pixel_entry_t;

endpackage : rt_types_pkg

// File: source/scene_int.sv
// Box intersection and hit/miss routing
`timescale 1ns/1ps

module scene_int
	import rt_scene_pkg::*, rt_types_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic ray_valid,
	output logic ray_stall,
	input ray_t ray,
	input coord_t box_xmin,
	input coord_t box_xmax,
	input coord_t box_ymin,
	input coord_t box_ymax,
	output logic hit_valid,
	input logic hit_stall,
	output pixel_entry_t hit_data,
	output logic miss_valid,
	input logic miss_stall,
	output pixel_entry_t miss_data
);

	coord_t ox;
	coord_t oy;
	logic in_box;
	logic r_valid;
	logic r_hit;
	pixel_entry_t r_entry;
	logic sel_stall;
	logic take;

	// Pull the origin out as signed coordinates
	assign ox = ray.origin_x;
	assign oy = ray.origin_y;

	// Bounds are inclusive on all four sides
	assign in_box = (ox >= box_xmin) && (ox <= box_xmax) &&
			(oy >= box_ymin) && (oy <= box_ymax);

	// Only the stream the held item is routed to can block it
	assign sel_stall = r_hit ? hit_stall : miss_stall;
	assign ray_stall = r_valid && sel_stall;
	assign take = ray_valid && !ray_stall;

	assign hit_valid = r_valid && r_hit;
	assign miss_valid = r_valid && !r_hit;
	assign hit_data = r_entry;
	assign miss_data = r_entry;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			r_valid <= 1'b0;
			r_hit <= 1'b0;
		end else if (take) begin
			r_valid <= 1'b1;
			r_hit <= in_box;
		end else if (r_valid && !sel_stall) begin
			// item left and nothing new came in
			r_valid <= 1'b0;
		end
	end

	// Pixel entry with its color picked by the box test
	always_ff @(posedge clk) begin
		if (take) begin
			r_entry.pixel_id <= ray.pixel_id;
			r_entry.color <= in_box ? COLOR_HIT : COLOR_MISS;
		end
	end

endmodule : scene_int

// File: source/stream_fifo.sv
// Show-ahead stream queue
`timescale 1ns/1ps

module stream_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	output logic in_stall,
	input payload_t in_data,
	output logic out_valid,
	input logic out_stall,
	output payload_t out_data
);

	payload_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic push;
	logic pop;

	assign in_stall = (count == DEPTH);
	assign out_valid = (count != '0);

	// Head item is always on the output
	assign out_data = mem[rd_ptr];

	assign push = in_valid && !in_stall;
	assign pop = out_valid && !out_stall;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			// Push and pop together leave the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule : stream_fifo
